/* common/timing_core_config.svh */
//--------------------------------------------------------------------
// Fixed machine widths and opcode constants for the timing core:
// word and state widths, ION/IOF codes, halt bit pattern
//--------------------------------------------------------------------
`ifndef TIMING_CORE_CONFIG_SVH
`define TIMING_CORE_CONFIG_SVH

`define WORD_BITS       12
`define STATE_BITS      5

// IOT codes of the interrupt enable pair
`define OPC_ION         12'o6001
`define OPC_IOF         12'o6002

// Group 2 operate with the HLT bit, bit 11 clear
`define OPC_HLT_MASK    12'o7403
`define OPC_HLT         12'o7402

`endif

/* common/timing_core_pkg.sv */
//--------------------------------------------------------------------
// Types of the timing core: machine word, major state encoding,
// EAE instruction classes and the pending data-break pair
//--------------------------------------------------------------------
`include "timing_core_config.svh"

package timing_core_pkg;

    typedef logic [0:`WORD_BITS-1] word_t;  // Bit 0 is the MSB

    typedef enum logic [`STATE_BITS-1:0] {
        F0, FW, F1, F2, F2A, F2B, F3,           // Fetch
        D0, DW, D1, D2, D3,                     // Defer
        E0, EW, E1, E2, E3,                     // Execute
        H0, HW, H1, H2, H3,                     // Halt and panel
        EAE0, EAE1, EAE2, EAE3, EAE4, EAE5,
        DB0, DB1, DB2                           // Data break, keep last
    } major_state_t;

    typedef enum logic [2:0] {
        NOT_EAE,
        EAE_NOP,
        EAE_SKIP_LOOP,      // Step counter and shift ops
        EAE_LOOP,           // NMI
        EAE_DOUBLE,         // Mode B MUY/DIV, DAD, DST
        EAE_DPSZ,
        EAE_PLAIN,
        EAE_GTF_SKIP
    } eae_class_t;

    typedef struct packed {
        logic write;        // Memory write, data from disk
        logic read;         // Memory read, data to disk
    } db_req_t;

endpackage

/* major_state/eae_decode.sv */
//--------------------------------------------------------------------
// EAE instruction classifier: mode A and mode B decode tables
//--------------------------------------------------------------------

module eae_decode (
    input  timing_core_pkg::word_t      instruction,
    input  logic                        eae_mode,
    output timing_core_pkg::eae_class_t eae_class
);
    import timing_core_pkg::*;

    // Pattern is 1111 xx S x CCC 1, S is bit 6 and CCC bits 8 to 10
    always_comb
    begin
        eae_class = NOT_EAE;
        if (!eae_mode)
        begin
            priority casez (instruction)
                12'b1111_??0?_0001: eae_class = EAE_NOP;        // 7401
                12'b1111_??0?_0011: eae_class = EAE_SKIP_LOOP;  // SCL 7403
                12'b1111_??0?_01?1: eae_class = EAE_SKIP_LOOP;  // MUY DIV
                12'b1111_??0?_1001: eae_class = EAE_LOOP;       // NMI 7411
                12'b1111_??0?_1??1: eae_class = EAE_SKIP_LOOP;  // SHL ASR LSR
                12'b1111_??1?_0001: eae_class = EAE_PLAIN;      // SCA 7441
                12'b1111_??1?_1001: eae_class = EAE_LOOP;       // SCA with NMI
                12'b1111_??1?_???1: eae_class = EAE_SKIP_LOOP;  // SCA with the rest
                default:            eae_class = NOT_EAE;
            endcase
        end
        else
        begin
            priority casez (instruction)
                12'b1100_0000_0110: eae_class = EAE_GTF_SKIP;   // 6006 skip on GTF
                12'b1111_??0?_0001: eae_class = EAE_NOP;
                12'b1111_??0?_0011: eae_class = EAE_PLAIN;      // ACS
                12'b1111_??0?_01?1: eae_class = EAE_DOUBLE;     // MUY DIV via defer
                12'b1111_??0?_1001: eae_class = EAE_LOOP;       // NMI
                12'b1111_??0?_1??1: eae_class = EAE_SKIP_LOOP;  // SHL ASR LSR
                12'b1111_??1?_0011: eae_class = EAE_DOUBLE;     // DAD 7443
                12'b1111_??1?_0101: eae_class = EAE_DOUBLE;     // DST 7445
                12'b1111_??1?_1001: eae_class = EAE_DPSZ;       // 7451
                12'b1111_??1?_???1: eae_class = EAE_PLAIN;      // SCA SWBA DPIC DCM SAM
                default:            eae_class = NOT_EAE;
            endcase
        end
    end

endmodule

/* major_state/major_state_machine.sv */
//--------------------------------------------------------------------
// Major state sequencer: fetch, defer, execute, halt, EAE and
// data-break states, with the EAE skip and interrupt entry
//--------------------------------------------------------------------
`include "timing_core_config.svh"

module major_state_machine (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          halt,
    input  logic                          single_step,
    input  logic                          cont,
    input  logic                          trigger,
    input  logic                          int_req,
    input  logic                          int_ena,
    input  logic                          int_inh,
    input  logic                          user_mode,
    input  logic                          eae_loop,
    input  logic                          gtf,
    input  logic                          db_write,
    input  logic                          db_read,
    input  timing_core_pkg::word_t        instruction,
    input  timing_core_pkg::word_t        ac,
    input  timing_core_pkg::word_t        mq,
    input  timing_core_pkg::eae_class_t   eae_class,
    output timing_core_pkg::major_state_t state,
    output logic                          eae_skip,
    output logic                          int_in_prog
);
    import timing_core_pkg::*;

    major_state_t state_d;
    major_state_t target;           // Next state if no break intervenes
    major_state_t resume_state;     // Where to go after the break
    major_state_t resume_d;
    logic         eae_skip_d;
    logic         in_prog_d;
    logic         brk;              // Transition can yield to a break
    logic         db;
    logic         int_ok;
    logic         ends_at_f3;
    logic         halt_op;
    logic         mode_b_class;

    assign db           = db_write | db_read;
    assign int_ok       = int_req & int_ena & ~int_inh;
    assign ends_at_f3   = (instruction[0:1] == 2'b11) ||       // IOT and operate
                          (instruction[0:3] == 4'b1010);       // JMP direct
    assign halt_op      = ((instruction & `OPC_HLT_MASK) == `OPC_HLT) && !user_mode;
    // Classes that only exist in mode B take the F2B path
    assign mode_b_class = (eae_class == EAE_DOUBLE) || (eae_class == EAE_DPSZ) ||
                          (eae_class == EAE_GTF_SKIP);

    always_comb
    begin
        target     = state;
        brk        = 1'b0;
        eae_skip_d = eae_skip;
        in_prog_d  = int_in_prog;
        case (state)
            F0:
            begin
                eae_skip_d = 1'b0;
                in_prog_d  = 1'b0;
                if (single_step && !cont) target = F0;
                else if (halt && !cont) target = H0;
                else target = FW;
            end
            FW: target = F1;
            F1:
            begin
                if (eae_class == NOT_EAE) target = F2;
                else if (mode_b_class) target = F2B;
                else target = F2A;
            end
            F2: target = F3;
            F2A, F2B:
            begin
                target = F3;
                case (eae_class)
                    EAE_SKIP_LOOP:
                    begin
                        eae_skip_d = 1'b1;
                        target     = EAE0;
                    end
                    EAE_LOOP: target = EAE0;
                    EAE_DOUBLE:
                    begin
                        eae_skip_d = 1'b1;          // Operand word follows
                        target     = D0;
                    end
                    EAE_DPSZ: if ((ac | mq) == '0) eae_skip_d = 1'b1;
                    EAE_GTF_SKIP: if (gtf) eae_skip_d = 1'b1;
                    default: target = F3;
                endcase
            end
            F3:
            begin
                if (ends_at_f3)
                begin
                    if (halt_op) target = H0;
                    else
                    begin
                        brk = 1'b1;
                        // No grant right after IOF
                        if (int_ok && !db && (instruction != `OPC_IOF))
                        begin
                            in_prog_d = 1'b1;
                            target    = E0;
                        end
                        else target = F0;
                    end
                end
                else
                begin
                    brk    = 1'b1;
                    target = instruction[3] ? D0 : E0;  // Indirect bit
                end
            end
            D0: target = (!single_step || cont) ? DW : D0;
            DW: target = D1;
            D1: target = D2;
            D2: target = D3;
            D3:
            begin
                brk = 1'b1;
                if (instruction[0:3] == 4'b1011)    // JMP I is done here
                begin
                    if (int_ok && !db)
                    begin
                        in_prog_d = 1'b1;
                        target    = E0;
                    end
                    else target = F0;
                end
                else if (eae_class == EAE_DOUBLE) target = EAE2;
                else target = E0;
            end
            E0: target = (!single_step || cont) ? EW : E0;
            EW: target = E1;
            E1: target = E2;
            E2: target = E3;
            E3:
            begin
                brk = 1'b1;
                if (int_ok && !int_in_prog && !db)
                begin
                    in_prog_d = 1'b1;
                    target    = E0;
                end
                else target = F0;
            end
            H0: target = HW;
            HW:
            begin
                if (cont) target = F0;
                else if (trigger) target = H1;
                else target = H0;
            end
            H1: target = H2;
            H2: target = H3;
            H3: target = H0;
            EAE0: target = EAE1;
            EAE1: target = eae_loop ? EAE1 : F3;    // Arithmetic loop runs outside
            EAE2: target = EAE3;
            EAE3: target = instruction[6] ? EAE4 : EAE0;   // MUY/DIV loop back
            EAE4: target = EAE5;
            EAE5: target = E3;
            DB0: target = DB1;
            DB1: target = db_write ? DB2 : resume_state;
            DB2: target = resume_state;
            default: target = H0;
        endcase

        if (brk && db)
        begin
            state_d  = DB0;
            resume_d = target;
        end
        else
        begin
            state_d  = target;
            resume_d = resume_state;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= H0;
            resume_state <= F0;
            eae_skip     <= 1'b0;
            int_in_prog  <= 1'b0;
        end
        else
        begin
            state        <= state_d;
            resume_state <= resume_d;
            eae_skip     <= eae_skip_d;
            int_in_prog  <= in_prog_d;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && (state <= DB2))
        else $error("major state left the legal encoding");

    // Interrupt cycle always starts with the execute state
    a_in_prog_e0: assert property (@(posedge clk) disable iff (reset)
        $rose(int_in_prog) |-> (state == E0))
        else $error("int_in_prog rose outside E0 entry");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the timing core regression with Verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module timing_core_tb -f timing_core.f -o timing_core_sim

output=$(./obj_dir/timing_core_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

/* timing_core.f */
+incdir+common
common/timing_core_pkg.sv
major_state/eae_decode.sv
major_state/major_state_machine.sv
verilog/interrupt_control.sv
verilog/data_break_latch.sv
verilog/timing_core.sv
verification/timing_core_tb.sv

/* verification/timing_core_tb.sv */
//----------------------------------------------------------------------
// Testbench for the timing core: clock and reset, a table of
// instruction rows with expected major-state sequences and flags,
// the stimulus loop, checks, timeout and closing summary
//----------------------------------------------------------------------
`include "timing_core_config.svh"

module timing_core_tb;
    import timing_core_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_SEQ      = 16;
    localparam int SEQ_BITS     = MAX_SEQ * `STATE_BITS;
    localparam int NUM_ROWS     = 16;
    localparam int MARGIN       = 64;

    localparam logic [3:0] RQ_NONE  = 4'b0000;
    localparam logic [3:0] RQ_READ  = 4'b0001;  // Disk read pulse in F1
    localparam logic [3:0] RQ_WRITE = 4'b0010;  // Disk write pulse in F1
    localparam logic [3:0] RQ_INT   = 4'b0100;  // int_req held for the row
    localparam logic [3:0] RQ_USER  = 4'b1000;

    typedef struct packed {
        word_t      instruction;
        logic       eae_mode;
        logic       fixed_data;     // Use the row's AC and MQ
        word_t      ac;
        word_t      mq;
        logic [3:0] req;
        logic [3:0] loops;          // Extra EAE1 cycles
        logic [2:0] flags;          // eae_skip, int_in_prog, int_ena at the end
    } row_t;

    logic         clk;
    logic         reset;
    logic         halt;
    logic         single_step;
    logic         cont;
    logic         trigger;
    logic         eae_mode;
    logic         eae_loop;
    logic         gtf;
    logic         int_req;
    logic         user_mode;
    logic         disk_write_req;
    logic         disk_read_req;
    word_t        instruction;
    word_t        ac;
    word_t        mq;
    major_state_t state;
    logic         eae_skip;
    logic         int_in_prog;
    logic         int_ena;

    row_t         rows[NUM_ROWS];
    string        row_name[NUM_ROWS];
    int           row_len[NUM_ROWS];
    major_state_t row_seq[NUM_ROWS][MAX_SEQ];
    int           row_count;
    int           state_errors;
    int           flag_errors;
    int           cycle_count = 0;
    int           cycle_limit;

    timing_core i_dut (
        .clk, .reset, .halt, .single_step, .cont, .trigger, .eae_mode, .eae_loop,
        .gtf, .int_req, .user_mode, .disk_write_req, .disk_read_req,
        .instruction, .ac, .mq, .state, .eae_skip, .int_in_prog, .int_ena
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sequence is given first state leftmost, right aligned in seq
    task automatic add_row(input string name, input word_t instr, input logic mode,
                           input logic [3:0] req, input logic [3:0] loops,
                           input logic fixed, input word_t ac_v, input word_t mq_v,
                           input logic [2:0] flags, input int len,
                           input logic [SEQ_BITS-1:0] seq);
        int i;
        row_name[row_count]         = name;
        rows[row_count].instruction = instr;
        rows[row_count].eae_mode    = mode;
        rows[row_count].fixed_data  = fixed;
        rows[row_count].ac          = ac_v;
        rows[row_count].mq          = mq_v;
        rows[row_count].req         = req;
        rows[row_count].loops       = loops;
        rows[row_count].flags       = flags;
        row_len[row_count]          = len;
        for (i = 0; i < len; i++)
            row_seq[row_count][i] = major_state_t'(seq[(len-1-i)*`STATE_BITS +: `STATE_BITS]);
        row_count++;
    endtask

    task automatic build_table();
        add_row("tad_direct", 12'o1020, 1'b0, RQ_NONE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 11,
                SEQ_BITS'({F0, FW, F1, F2, F3, E0, EW, E1, E2, E3, F0}));
        add_row("tad_indirect", 12'o1420, 1'b0, RQ_NONE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 16,
                SEQ_BITS'({F0, FW, F1, F2, F3, D0, DW, D1, D2, D3, E0, EW, E1, E2, E3, F0}));
        add_row("hlt_halts", 12'o7402, 1'b0, RQ_NONE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 8,
                SEQ_BITS'({F0, FW, F1, F2, F3, H0, HW, F0}));
        add_row("hlt_user", 12'o7402, 1'b0, RQ_USER, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 6,
                SEQ_BITS'({F0, FW, F1, F2, F3, F0}));
        add_row("db_read", 12'o1020, 1'b0, RQ_READ, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 13,
                SEQ_BITS'({F0, FW, F1, F2, F3, DB0, DB1, E0, EW, E1, E2, E3, F0}));
        add_row("db_write", 12'o1020, 1'b0, RQ_WRITE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 14,
                SEQ_BITS'({F0, FW, F1, F2, F3, DB0, DB1, DB2, E0, EW, E1, E2, E3, F0}));
        // ION, then one held-off instruction, then the grant
        add_row("ion", 12'o6001, 1'b0, RQ_NONE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 6,
                SEQ_BITS'({F0, FW, F1, F2, F3, F0}));
        add_row("ion_hold", 12'o7000, 1'b0, RQ_INT, 4'd0, 1'b0, 12'o0, 12'o0, 3'b001, 6,
                SEQ_BITS'({F0, FW, F1, F2, F3, F0}));
        add_row("int_taken", 12'o7000, 1'b0, RQ_INT, 4'd0, 1'b0, 12'o0, 12'o0, 3'b010, 11,
                SEQ_BITS'({F0, FW, F1, F2, F3, E0, EW, E1, E2, E3, F0}));
        add_row("ion_again", 12'o6001, 1'b0, RQ_NONE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 6,
                SEQ_BITS'({F0, FW, F1, F2, F3, F0}));
        add_row("iof", 12'o6002, 1'b0, RQ_INT, 4'd0, 1'b0, 12'o0, 12'o0, 3'b001, 6,
                SEQ_BITS'({F0, FW, F1, F2, F3, F0}));
        add_row("iof_hold", 12'o7000, 1'b0, RQ_INT, 4'd0, 1'b0, 12'o0, 12'o0, 3'b000, 6,
                SEQ_BITS'({F0, FW, F1, F2, F3, F0}));
        add_row("dpsz_zero", 12'o7451, 1'b1, RQ_NONE, 4'd0, 1'b1, 12'o0, 12'o0, 3'b100, 6,
                SEQ_BITS'({F0, FW, F1, F2B, F3, F0}));
        add_row("dpsz_nonzero", 12'o7451, 1'b1, RQ_NONE, 4'd0, 1'b1, 12'o0040, 12'o4000,
                3'b000, 6, SEQ_BITS'({F0, FW, F1, F2B, F3, F0}));
        add_row("shl_loop", 12'o7413, 1'b0, RQ_NONE, 4'd3, 1'b0, 12'o0, 12'o0, 3'b100, 11,
                SEQ_BITS'({F0, FW, F1, F2A, EAE0, EAE1, EAE1, EAE1, EAE1, F3, F0}));
        add_row("asr_short", 12'o7415, 1'b0, RQ_NONE, 4'd0, 1'b0, 12'o0, 12'o0, 3'b100, 8,
                SEQ_BITS'({F0, FW, F1, F2A, EAE0, EAE1, F3, F0}));
    endtask

    task automatic check_state(input string name, input int step, input major_state_t exp);
        if (state !== exp)
        begin
            state_errors++;
            $display("FAIL %s step %0d: expected %s, actual %s",
                     name, step, exp.name(), state.name());
        end
    endtask

    task automatic check_flag(input string name, input string flag, input logic exp,
                              input logic act);
        if (act !== exp)
        begin
            flag_errors++;
            $display("FAIL %s %s: expected %0b, actual %0b", name, flag, exp, act);
        end
    endtask

    // Starts in F0 on a falling edge, ends on the F0 that closes the row
    task automatic run_row(input int n);
        row_t        r;
        logic [31:0] rnd;
        logic [3:0]  loops_done;
        int          i;
        r          = rows[n];
        loops_done = 4'd0;
        while (state != F0)
            @(negedge clk);
        check_state(row_name[n], 0, row_seq[n][0]);
        instruction = r.instruction;
        eae_mode    = r.eae_mode;
        int_req     = |(r.req & RQ_INT);
        user_mode   = |(r.req & RQ_USER);
        if (r.fixed_data)
        begin
            ac = r.ac;
            mq = r.mq;
        end
        else
        begin
            rnd = $urandom();
            ac  = rnd[11:0];
            rnd = $urandom();
            mq  = rnd[11:0];
        end
        for (i = 1; i < row_len[n]; i++)
        begin
            @(negedge clk);
            check_state(row_name[n], i, row_seq[n][i]);
            disk_read_req  = (state == F1) && |(r.req & RQ_READ);    // One-cycle pulse
            disk_write_req = (state == F1) && |(r.req & RQ_WRITE);
            eae_loop       = 1'b0;
            if ((state == EAE1) && (loops_done < r.loops))
            begin
                eae_loop   = 1'b1;
                loops_done = loops_done + 4'd1;
            end
        end
        check_flag(row_name[n], "eae_skip", r.flags[2], eae_skip);
        check_flag(row_name[n], "int_in_prog", r.flags[1], int_in_prog);
        check_flag(row_name[n], "int_ena", r.flags[0], int_ena);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Errors: %0d state, %0d flag, %0d timeout",
                 state_errors, flag_errors, timed_out ? 1 : 0);
        if ((state_errors == 0) && (flag_errors == 0) && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("ERROR: run timed out after %0d cycles", cycle_count);
            finish_run(1'b1);
        end
    end

    initial
    begin
        int          total;
        int          n;
        void'($urandom(32'hc552_ce2e));
        reset          = 1'b1;
        halt           = 1'b0;
        single_step    = 1'b0;
        cont           = 1'b1;      // Held high for the whole run
        trigger        = 1'b0;
        eae_mode       = 1'b0;
        eae_loop       = 1'b0;
        gtf            = 1'b0;
        int_req        = 1'b0;
        user_mode      = 1'b0;
        disk_write_req = 1'b0;
        disk_read_req  = 1'b0;
        instruction    = '0;
        ac             = '0;
        mq             = '0;
        row_count      = 0;
        state_errors   = 0;
        flag_errors    = 0;
        build_table();
        total = RESET_CYCLES + 3;
        for (n = 0; n < row_count; n++)
            total += row_len[n];
        cycle_limit = total + MARGIN;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_state("reset_boot", 0, H0);
        @(negedge clk);
        check_state("reset_boot", 1, HW);
        @(negedge clk);
        check_state("reset_boot", 2, F0);

        for (n = 0; n < row_count; n++)
            run_row(n);
        finish_run(1'b0);
    end

endmodule

/* verilog/data_break_latch.sv */
//--------------------------------------------------------------------
// Disk data-break request latch, held until the break completes
//--------------------------------------------------------------------

module data_break_latch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disk_write_req,
    input  logic                          disk_read_req,
    input  timing_core_pkg::major_state_t state,
    output logic                          db_write,
    output logic                          db_read
);
    import timing_core_pkg::*;

    db_req_t pending;

    always_ff @(posedge clk)
    begin
        if (reset)
            pending <= '0;
        else
        begin
            if (disk_write_req) pending.write <= 1'b1;   // New pulse wins over clear
            else if (state == DB2) pending.write <= 1'b0;
            if (disk_read_req) pending.read <= 1'b1;
            else if ((state == DB1) && !pending.write) pending.read <= 1'b0;
        end
    end

    assign db_write = pending.write;
    assign db_read  = pending.read;

    // Disk controller moves one direction at a time
    a_one_direction: assert property (@(posedge clk) disable iff (reset)
        !(db_write && db_read))
        else $error("read and write data breaks pending together");

endmodule

/* verilog/interrupt_control.sv */
//--------------------------------------------------------------------
// Interrupt enable flip-flop with the ION one-instruction inhibit
//--------------------------------------------------------------------
`include "timing_core_config.svh"

module interrupt_control (
    input  logic                          clk,
    input  logic                          reset,
    input  timing_core_pkg::major_state_t state,
    input  timing_core_pkg::word_t        instruction,
    input  logic                          int_in_prog,
    output logic                          int_ena,
    output logic                          int_inh
);
    import timing_core_pkg::*;

    major_state_t last_state;
    word_t        last_instr;       // Instruction seen in its last state
    logic         in_prog_q;
    logic         instr_end;
    logic         inh_at_end;

    // F0 entered from an instruction's final state or a break after it
    assign instr_end = (state == F0) && (last_state inside {F3, D3, E3, DB1, DB2});

    always_ff @(posedge clk)
    begin
        if (state inside {F3, D3, E3}) last_instr <= instruction;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_state <= H0;
            in_prog_q  <= 1'b0;
            int_ena    <= 1'b0;
            int_inh    <= 1'b0;
            inh_at_end <= 1'b0;
        end
        else
        begin
            last_state <= state;
            in_prog_q  <= int_in_prog;
            if ((state == E0) && int_in_prog && !in_prog_q)
                int_ena <= 1'b0;                // Grant turns interrupts off
            else if (instr_end)
            begin
                inh_at_end <= int_inh;
                if (last_instr == `OPC_ION)
                begin
                    int_ena <= 1'b1;
                    int_inh <= 1'b1;            // Hold off until the next one ends
                end
                else
                begin
                    if (last_instr == `OPC_IOF) int_ena <= 1'b0;
                    int_inh <= 1'b0;
                end
            end
        end
    end

    a_inh_one_instr: assert property (@(posedge clk) disable iff (reset)
        (instr_end && inh_at_end) |-> !int_inh)
        else $error("int_inh held across two instruction ends");

endmodule

/* verilog/timing_core.sv */
//--------------------------------------------------------------------
// Timing core top: EAE decode, major state sequencer, interrupt
// enable and data-break latch
//--------------------------------------------------------------------

module timing_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          halt,
    input  logic                          single_step,
    input  logic                          cont,
    input  logic                          trigger,
    input  logic                          eae_mode,
    input  logic                          eae_loop,
    input  logic                          gtf,
    input  logic                          int_req,
    input  logic                          user_mode,
    input  logic                          disk_write_req,
    input  logic                          disk_read_req,
    input  timing_core_pkg::word_t        instruction,
    input  timing_core_pkg::word_t        ac,
    input  timing_core_pkg::word_t        mq,
    output timing_core_pkg::major_state_t state,
    output logic                          eae_skip,
    output logic                          int_in_prog,
    output logic                          int_ena
);
    import timing_core_pkg::*;

    eae_class_t eae_class;
    logic       int_inh;
    logic       db_write;
    logic       db_read;

    eae_decode i_eae_decode (.instruction, .eae_mode, .eae_class);

    major_state_machine i_major_state_machine (
        .clk, .reset, .halt, .single_step, .cont, .trigger,
        .int_req, .int_ena, .int_inh, .user_mode, .eae_loop, .gtf,
        .db_write, .db_read, .instruction, .ac, .mq, .eae_class,
        .state, .eae_skip, .int_in_prog
    );

    interrupt_control i_interrupt_control (
        .clk, .reset, .state, .instruction, .int_in_prog, .int_ena, .int_inh
    );

    data_break_latch i_data_break_latch (
        .clk, .reset, .disk_write_req, .disk_read_req, .state, .db_write, .db_read
    );

endmodule
